//--- vlog.f
rtl/rv_pkg.sv
rtl/rv_i_decoder.sv
rtl/rv_m_decoder.sv
rtl/rv_decoder.sv
rtl/rv_ex_stage.sv
rtl/rv_wb_regfile.sv
rtl/rv_core_top.sv
tb/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

  localparam int N_RAND  = 300;            // Random issue slots
  localparam int N_SLOTS = N_RAND + 60;    // Plus reset, directed and idle slots

  typedef struct packed {
    logic [31:0] due;    // Cycle count while on the wb outputs
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        ill;
    logic        ecall;
    logic        ebrk;
  } retire_t;

  logic                clk;
  logic                rst_i;
  rv_pkg::if_id_pipe_t if_id_pipe;
  logic                deassert_we;
  logic                wb_valid;
  logic                wb_we;
  logic [4:0]          wb_rd;
  logic [31:0]         wb_data;
  logic                ill;
  logic                ecall;
  logic                ebrk;

  logic [31:0] lfsr;
  logic [31:0] cyc;
  logic [31:0] model_rf [32];   // Architectural state, program order
  retire_t     exp_q [$];
  retire_t     exp_rec;         // Record under check this cycle
  logic        chk_en;
  int          value_errors;
  int          other_errors;
  int          retired;

  rv_core_top DUT (
    .clk            (clk),
    .rst_i          (rst_i),
    .if_id_pipe_i   (if_id_pipe),
    .deassert_we_i  (deassert_we),
    .wb_valid_o     (wb_valid),
    .wb_we_o        (wb_we),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .illegal_insn_o (ill),
    .sys_ecall_o    (ecall),
    .sys_ebrk_o     (ebrk)
  );

  always #5 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] random_instr();
    logic [2:0]  cls;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    cls = 3'(rand_bits(3));
    f3  = 3'(rand_bits(3));
    rd  = 5'(rand_bits(3));    // x0..x7 keeps dependencies close
    rs1 = 5'(rand_bits(3));
    rs2 = 5'(rand_bits(3));
    imm = 12'(rand_bits(12));
    case (cls)
      3'd0, 3'd1: return r_type(((f3 == 3'd0) || (f3 == 3'd5)) && imm[0] ? 7'h20 : 7'h00,
                                rs2, rs1, f3, rd);
      3'd2, 3'd3: begin
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'b0};   // SRLI or SRAI
        return i_type(imm, rs1, f3, rd);
      end
      3'd4:    return {20'(rand_bits(20)), rd, 7'h37};
      3'd5:    return r_type(7'h01, rs2, rs1, {1'b0, f3[1:0]}, rd);
      3'd6:    return r_type(7'h01, rs2, rs1, {1'b1, f3[1:0]}, rd);  // Division
      default: return f3[0] ? 32'h0000_0073 : 32'h0010_0073;
    endcase
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Sign extend to 64 bits, the product mod 2^64 is exact
  function automatic logic [31:0] mul_ref(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = {{32{a[31] && (f3 != 3'd3)}}, a};   // Unsigned only for MULHU
    eb = {{32{b[31] && !f3[1]}}, b};         // Signed for MUL and MULH
    p  = ea * eb;
    return (f3 == 3'd0) ? p[31:0] : p[63:32];
  endfunction

  function automatic retire_t model_step(input logic [31:0] ins, input logic ill_c,
                                         input logic kill);
    retire_t     r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic        legal;
    f3    = ins[14:12];
    f7    = ins[31:25];
    a     = model_rf[ins[19:15]];
    b     = model_rf[ins[24:20]];
    legal = 1'b0;
    r     = '0;
    r.rd  = ins[11:7];
    case (ins[6:0])
      7'h33: begin
        legal  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))) ||
                 ((f7 == 7'h01) && !f3[2]);
        r.data = (f7 == 7'h01) ? mul_ref(f3, a, b) : alu_ref(f3, f7[5], a, b);
      end
      7'h13: begin
        legal  = !(((f3 == 3'd1) && (f7 != 7'h00)) ||
                   ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20)));
        r.data = alu_ref(f3, (f3 == 3'd5) && f7[5], a, {{20{ins[31]}}, ins[31:20]});
      end
      7'h37: begin
        legal  = 1'b1;
        r.data = {ins[31:12], 12'h000};
      end
      7'h73: begin
        r.ecall = (ins == 32'h0000_0073);
        r.ebrk  = (ins == 32'h0010_0073);
        legal   = r.ecall || r.ebrk;
      end
      default: ;  // Unknown opcode
    endcase
    r.we  = legal && !r.ecall && !r.ebrk && !ill_c && !kill;
    r.ill = (!legal || ill_c) && !kill;
    if (ill_c || kill) begin
      r.ecall = 1'b0;
      r.ebrk  = 1'b0;
    end
    if (r.we && (r.rd != 5'd0)) model_rf[r.rd] = r.data;  // x0 never changes
    return r;
  endfunction

  // Called 1 ns after an edge, sampled at the next edge
  task automatic issue(input logic [31:0] instr, input logic ill_c, input logic kill);
    retire_t r;
    r     = model_step(instr, ill_c, kill);
    r.due = cyc + 2;
    exp_q.push_back(r);
    if_id_pipe  = '{valid: 1'b1, instr: instr, illegal_c_insn: ill_c};
    deassert_we = kill;
    @(posedge clk);
    #1;
  endtask

  task automatic idle();
    if_id_pipe  = '0;
    deassert_we = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    value_errors++;
  endtask

  ////////////////////////////////////////
  // Retire monitor and checks
  ////////////////////////////////////////
  always @(posedge clk) begin
    #2;                   // Outputs settled, checked at the falling edge
    chk_en = 1'b0;
    if (!rst_i && wb_valid) begin
      if (exp_q.size() == 0) begin
        $display("Instruction retired at %0t with nothing outstanding", $time);
        other_errors++;
      end else begin
        exp_rec = exp_q.pop_front();
        chk_en  = 1'b1;
        retired++;
      end
    end else if ((exp_q.size() != 0) && (exp_q[0].due <= cyc)) begin
      $display("Instruction due in cycle %0d never retired", exp_q[0].due);
      void'(exp_q.pop_front());
      other_errors++;
    end
  end

  a_idle: assert property (@(negedge clk) disable iff (rst_i)
            !wb_valid |-> !(wb_we || ill || ecall || ebrk))
    else show_mismatch("wb_we_o,illegal_insn_o,sys_ecall_o,sys_ebrk_o", '0,
                       {wb_we, ill, ecall, ebrk});
  a_due: assert property (@(negedge clk) chk_en |-> (cyc == exp_rec.due))
    else show_mismatch("retire cycle", exp_rec.due, cyc);
  a_we: assert property (@(negedge clk) chk_en |-> (wb_we == exp_rec.we))
    else show_mismatch("wb_we_o", exp_rec.we, wb_we);
  a_rd: assert property (@(negedge clk) (chk_en && exp_rec.we) |-> (wb_rd == exp_rec.rd))
    else show_mismatch("wb_rd_o", exp_rec.rd, wb_rd);
  a_data: assert property (@(negedge clk) (chk_en && exp_rec.we) |-> (wb_data == exp_rec.data))
    else show_mismatch("wb_data_o", exp_rec.data, wb_data);
  a_ill: assert property (@(negedge clk) chk_en |-> (ill == exp_rec.ill))
    else show_mismatch("illegal_insn_o", exp_rec.ill, ill);
  a_ecall: assert property (@(negedge clk) chk_en |-> (ecall == exp_rec.ecall))
    else show_mismatch("sys_ecall_o", exp_rec.ecall, ecall);
  a_ebrk: assert property (@(negedge clk) chk_en |-> (ebrk == exp_rec.ebrk))
    else show_mismatch("sys_ebrk_o", exp_rec.ebrk, ebrk);

  // Watchdog
  initial begin
    #(N_SLOTS * 10 + 200);
    $display("Watchdog expired at %0t, the stimulus did not finish", $time);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] ins;
    logic        ill_c;
    logic        kill;
    clk          = 1'b0;
    rst_i        = 1'b1;
    if_id_pipe   = '0;
    deassert_we  = 1'b0;
    lfsr         = 32'h1f79;
    cyc          = '0;
    chk_en       = 1'b0;
    value_errors = 0;
    other_errors = 0;
    retired      = 0;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;
    repeat (4) idle();                                       // Quiet after reset
    issue({20'h80000, 5'd1, 7'h37}, 1'b0, 1'b0);             // x1 = most negative
    issue(i_type(12'hfff, 5'd0, 3'd0, 5'd2), 1'b0, 1'b0);    // x2 = -1
    issue(i_type(12'hfff, 5'd1, 3'd0, 5'd3), 1'b0, 1'b0);    // x3 = most positive
    issue(r_type(7'h01, 5'd1, 5'd1, 3'd1, 5'd4), 1'b0, 1'b0);   // MULH min*min
    issue(r_type(7'h01, 5'd2, 5'd1, 3'd2, 5'd5), 1'b0, 1'b0);   // MULHSU
    issue(r_type(7'h01, 5'd2, 5'd2, 3'd3, 5'd6), 1'b0, 1'b0);   // MULHU
    issue(r_type(7'h01, 5'd3, 5'd3, 3'd0, 5'd7), 1'b0, 1'b0);   // MUL max*max
    issue(i_type(12'h404, 5'd1, 3'd5, 5'd8), 1'b0, 1'b0);       // SRAI
    issue(i_type(12'h004, 5'd8, 3'd5, 5'd9), 1'b0, 1'b0);       // SRLI, distance 1
    issue(r_type(7'h00, 5'd3, 5'd1, 3'd2, 5'd10), 1'b0, 1'b0);  // SLT
    issue(r_type(7'h00, 5'd3, 5'd1, 3'd3, 5'd11), 1'b0, 1'b0);  // SLTU
    issue(i_type(12'h800, 5'd2, 3'd2, 5'd12), 1'b0, 1'b0);      // SLTI, negative imm
    issue(r_type(7'h20, 5'd2, 5'd3, 3'd0, 5'd13), 1'b0, 1'b0);  // SUB
    issue(i_type(12'h005, 5'd1, 3'd0, 5'd0), 1'b0, 1'b0);       // Write to x0
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd14), 1'b0, 1'b0);  // Reads x0
    issue(r_type(7'h01, 5'd2, 5'd1, 3'd4, 5'd15), 1'b0, 1'b0);  // DIV is illegal
    issue(32'h0000_007f, 1'b0, 1'b0);                           // Unknown opcode
    issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd16), 1'b1, 1'b0);  // Flagged compressed
    issue(32'h0000_0073, 1'b0, 1'b0);
    issue(32'h0010_0073, 1'b0, 1'b0);
    issue(i_type(12'h04d, 5'd0, 3'd0, 5'd1), 1'b0, 1'b1);       // Deasserted write
    issue(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd17), 1'b0, 1'b0);  // Old x1
    issue(32'h0000_0073, 1'b0, 1'b1);                           // Deasserted ECALL
    for (int n = 0; n < N_RAND; n++) begin
      if (rand_bits(2) == 0) begin
        idle();                                              // Gap in valid
      end else begin
        ins   = random_instr();
        ill_c = (rand_bits(5) == 0);
        kill  = (rand_bits(4) == 0);
        issue(ins, ill_c, kill);
      end
    end
    repeat (6) idle();                                       // Drain
    if (exp_q.size() != 0) begin
      $display("%0d instructions still outstanding at the end", exp_q.size());
      other_errors++;
    end
    $display("Summary: %0d retired, %0d value errors, %0d other errors",
             retired, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
  input  logic                clk,
  input  logic                rst_i,
  input  rv_pkg::if_id_pipe_t if_id_pipe_i,   // Sampled on every edge with valid high
  input  logic                deassert_we_i,
  output logic                wb_valid_o,     // One cycle per retired instruction
  output logic                wb_we_o,
  output logic [4:0]          wb_rd_o,
  output logic [31:0]         wb_data_o,
  output logic                illegal_insn_o,
  output logic                sys_ecall_o,
  output logic                sys_ebrk_o
);

  rv_pkg::decoder_ctrl_t decoder_ctrl;
  logic [31:0]           rs1_rdata;
  logic [31:0]           rs2_rdata;
  rv_pkg::ex_wb_pipe_t   ex_wb_next;  // From EX, combinational
  rv_pkg::ex_wb_pipe_t   ex_wb_q;     // EX/WB register

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  rv_decoder decoder_i (
    .if_id_pipe_i   (if_id_pipe_i),
    .deassert_we_i  (deassert_we_i),
    .decoder_ctrl_o (decoder_ctrl)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  rv_ex_stage ex_stage_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .if_id_pipe_i   (if_id_pipe_i),
    .decoder_ctrl_i (decoder_ctrl),
    .rs1_rdata_i    (rs1_rdata),
    .rs2_rdata_i    (rs2_rdata),
    .ex_wb_i        (ex_wb_q),
    .ex_wb_o        (ex_wb_next)
  );

  ////////////////////////////////////////
  // Writeback and register file
  ////////////////////////////////////////
  rv_wb_regfile wb_regfile_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .ex_wb_i        (ex_wb_next),
    .rs1_addr_i     (if_id_pipe_i.instr[19:15]),  // Read during decode
    .rs2_addr_i     (if_id_pipe_i.instr[24:20]),
    .rs1_rdata_o    (rs1_rdata),
    .rs2_rdata_o    (rs2_rdata),
    .ex_wb_o        (ex_wb_q),
    .wb_valid_o     (wb_valid_o),
    .wb_we_o        (wb_we_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o),
    .illegal_insn_o (illegal_insn_o),
    .sys_ecall_o    (sys_ecall_o),
    .sys_ebrk_o     (sys_ebrk_o)
  );

endmodule

//--- rtl/rv_wb_regfile.sv
`timescale 1ns/100ps

module rv_wb_regfile (
  input  logic                clk,
  input  logic                rst_i,
  input  rv_pkg::ex_wb_pipe_t ex_wb_i,
  input  logic [4:0]          rs1_addr_i,
  input  logic [4:0]          rs2_addr_i,
  output logic [31:0]         rs1_rdata_o,
  output logic [31:0]         rs2_rdata_o,
  output rv_pkg::ex_wb_pipe_t ex_wb_o,        // Registered copy, for forwarding
  output logic                wb_valid_o,
  output logic                wb_we_o,
  output logic [4:0]          wb_rd_o,
  output logic [31:0]         wb_data_o,
  output logic                illegal_insn_o,
  output logic                sys_ecall_o,
  output logic                sys_ebrk_o
);

  rv_pkg::ex_wb_pipe_t     ex_wb_q;
  logic [rv_pkg::XLEN-1:0] rf_q [1:31];  // x0 is not stored

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_wb_q.valid          <= 1'b0;
      ex_wb_q.rf_we          <= 1'b0;
      ex_wb_q.illegal_insn   <= 1'b0;
      ex_wb_q.sys_ecall_insn <= 1'b0;
      ex_wb_q.sys_ebrk_insn  <= 1'b0;
    end else begin
      ex_wb_q.valid          <= ex_wb_i.valid;
      ex_wb_q.rf_we          <= ex_wb_i.rf_we;
      ex_wb_q.illegal_insn   <= ex_wb_i.illegal_insn;
      ex_wb_q.sys_ecall_insn <= ex_wb_i.sys_ecall_insn;
      ex_wb_q.sys_ebrk_insn  <= ex_wb_i.sys_ebrk_insn;
    end
    ex_wb_q.rd     <= ex_wb_i.rd;
    ex_wb_q.result <= ex_wb_i.result;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (ex_wb_q.rf_we && (ex_wb_q.rd != 5'd0)) begin
      rf_q[ex_wb_q.rd] <= ex_wb_q.result;
    end
  end

  // x0 reads zero, same-cycle write goes straight through
  function automatic logic [31:0] rf_read(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (ex_wb_q.rf_we && (ex_wb_q.rd == addr)) begin
      return ex_wb_q.result;
    end
    return rf_q[addr];
  endfunction

  always_comb begin
    rs1_rdata_o = rf_read(rs1_addr_i);
    rs2_rdata_o = rf_read(rs2_addr_i);
  end

  assign ex_wb_o        = ex_wb_q;
  assign wb_valid_o     = ex_wb_q.valid;
  assign wb_we_o        = ex_wb_q.rf_we;
  assign wb_rd_o        = ex_wb_q.rd;
  assign wb_data_o      = ex_wb_q.result;
  assign illegal_insn_o = ex_wb_q.illegal_insn;
  assign sys_ecall_o    = ex_wb_q.sys_ecall_insn;
  assign sys_ebrk_o     = ex_wb_q.sys_ebrk_insn;

endmodule

//--- rtl/rv_ex_stage.sv
`timescale 1ns/100ps

module rv_ex_stage (
  input  logic                  clk,
  input  logic                  rst_i,
  input  rv_pkg::if_id_pipe_t   if_id_pipe_i,
  input  rv_pkg::decoder_ctrl_t decoder_ctrl_i,
  input  logic [31:0]           rs1_rdata_i,   // Register file, write-through
  input  logic [31:0]           rs2_rdata_i,
  input  rv_pkg::ex_wb_pipe_t   ex_wb_i,       // EX/WB register, forwarding source
  output rv_pkg::ex_wb_pipe_t   ex_wb_o        // Next EX/WB contents
);

  rv_pkg::id_ex_pipe_t     id_ex_q;
  logic [31:0]             instr;
  logic [rv_pkg::XLEN-1:0] imm;
  logic                    fwd_a;
  logic                    fwd_b;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] reg_b;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_result;
  logic signed [32:0]      mul_a;
  logic signed [32:0]      mul_b;
  logic signed [65:0]      mul_product;
  logic [rv_pkg::XLEN-1:0] ex_result;

  assign instr = if_id_pipe_i.instr;
  assign imm   = (instr[6:0] == rv_pkg::OPCODE_LUI) ? {instr[31:12], 12'h000}  // U-type
                                                     : {{20{instr[31]}}, instr[31:20]};

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q.valid <= if_id_pipe_i.valid;
    end
    id_ex_q.ctrl      <= decoder_ctrl_i;  // Payload, qualified by valid
    id_ex_q.rd        <= instr[11:7];
    id_ex_q.rs1_addr  <= instr[19:15];
    id_ex_q.rs2_addr  <= instr[24:20];
    id_ex_q.rs1_rdata <= rs1_rdata_i;
    id_ex_q.rs2_rdata <= rs2_rdata_i;
    id_ex_q.imm       <= imm;
  end

  // Older instruction in EX/WB wins over the stale register value
  assign fwd_a = ex_wb_i.rf_we && (ex_wb_i.rd == id_ex_q.rs1_addr) && (id_ex_q.rs1_addr != 5'd0);
  assign fwd_b = ex_wb_i.rf_we && (ex_wb_i.rd == id_ex_q.rs2_addr) && (id_ex_q.rs2_addr != 5'd0);

  assign op_a  = !id_ex_q.ctrl.rf_re[0] ? '0 : fwd_a ? ex_wb_i.result : id_ex_q.rs1_rdata;
  assign reg_b = !id_ex_q.ctrl.rf_re[1] ? '0 : fwd_b ? ex_wb_i.result : id_ex_q.rs2_rdata;
  assign op_b  = (id_ex_q.ctrl.alu_op_b_mux_sel == rv_pkg::OP_B_IMM) ? id_ex_q.imm : reg_b;

  always_comb begin
    case (id_ex_q.ctrl.alu_operator)
      rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_result = op_a << op_b[4:0];
      rv_pkg::ALU_SLT:  alu_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_result = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_result = op_a >> op_b[4:0];
      rv_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
      rv_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv_pkg::ALU_AND:  alu_result = op_a & op_b;
      rv_pkg::ALU_LUI:  alu_result = op_b;  // Immediate already shifted
      default:          alu_result = '0;
    endcase
  end

  // 33x33 signed covers all four MUL variants
  assign mul_a       = {id_ex_q.ctrl.mul_signed_mode[1] & op_a[31], op_a};
  assign mul_b       = {id_ex_q.ctrl.mul_signed_mode[0] & op_b[31], op_b};
  assign mul_product = mul_a * mul_b;

  assign ex_result = id_ex_q.ctrl.mul_en ?
                     ((id_ex_q.ctrl.mul_operator == rv_pkg::MUL_L) ? mul_product[31:0]
                                                                   : mul_product[63:32]) :
                     id_ex_q.ctrl.alu_en ? alu_result : '0;

  always_comb begin
    ex_wb_o.valid          = id_ex_q.valid;
    ex_wb_o.rf_we          = id_ex_q.valid & id_ex_q.ctrl.rf_we;
    ex_wb_o.rd             = id_ex_q.rd;
    ex_wb_o.result         = ex_result;
    ex_wb_o.illegal_insn   = id_ex_q.valid & id_ex_q.ctrl.illegal_insn;
    ex_wb_o.sys_ecall_insn = id_ex_q.valid & id_ex_q.ctrl.sys_ecall_insn;
    ex_wb_o.sys_ebrk_insn  = id_ex_q.valid & id_ex_q.ctrl.sys_ebrk_insn;
  end

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::if_id_pipe_t   if_id_pipe_i,
  input  logic                  deassert_we_i,   // Kill side effects of this instruction
  output rv_pkg::decoder_ctrl_t decoder_ctrl_o
);

  rv_pkg::decoder_ctrl_t decoder_i_ctrl;
  rv_pkg::decoder_ctrl_t decoder_m_ctrl;
  rv_pkg::decoder_ctrl_t ctrl_subdec;  // Selected subdecoder output
  rv_pkg::decoder_ctrl_t ctrl_mux;     // After compressed override

  rv_i_decoder i_decoder_i (
    .instr_rdata_i  (if_id_pipe_i.instr),
    .decoder_ctrl_o (decoder_i_ctrl)
  );

  rv_m_decoder m_decoder_i (
    .instr_rdata_i  (if_id_pipe_i.instr),
    .decoder_ctrl_o (decoder_m_ctrl)
  );

  // M first, then I, else nothing matched
  always_comb begin
    if (!decoder_m_ctrl.illegal_insn) begin
      ctrl_subdec = decoder_m_ctrl;
    end else if (!decoder_i_ctrl.illegal_insn) begin
      ctrl_subdec = decoder_i_ctrl;
    end else begin
      ctrl_subdec = rv_pkg::DECODER_CTRL_ILLEGAL_INSN;
    end
  end

  assign ctrl_mux = if_id_pipe_i.illegal_c_insn ? rv_pkg::DECODER_CTRL_ILLEGAL_INSN : ctrl_subdec;

  ////////////////////////////////////////
  // Deassert suppression
  ////////////////////////////////////////
  always_comb begin
    decoder_ctrl_o = ctrl_mux;
    if (deassert_we_i) begin
      decoder_ctrl_o.alu_en         = 1'b0;
      decoder_ctrl_o.mul_en         = 1'b0;
      decoder_ctrl_o.rf_re          = 2'b00;
      decoder_ctrl_o.rf_we          = 1'b0;
      decoder_ctrl_o.sys_ecall_insn = 1'b0;
      decoder_ctrl_o.sys_ebrk_insn  = 1'b0;
      decoder_ctrl_o.illegal_insn   = 1'b0;  // Still retires, but silently
    end
  end

endmodule

//--- rtl/rv_m_decoder.sv
`timescale 1ns/100ps

module rv_m_decoder (
  input  logic [31:0]           instr_rdata_i,
  output rv_pkg::decoder_ctrl_t decoder_ctrl_o
);

  logic [2:0] funct3;
  logic       is_mul;  // OP with funct7 1 and funct3 0..3

  assign funct3 = instr_rdata_i[14:12];
  assign is_mul = (instr_rdata_i[6:0] == rv_pkg::OPCODE_OP) &&
                  (instr_rdata_i[31:25] == 7'h01) && !funct3[2];  // DIV/REM not decoded

  always_comb begin
    decoder_ctrl_o = rv_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (is_mul) begin
      decoder_ctrl_o.mul_en       = 1'b1;
      decoder_ctrl_o.mul_operator = (funct3 == 3'b000) ? rv_pkg::MUL_L : rv_pkg::MUL_H;
      case (funct3[1:0])
        2'b10:   decoder_ctrl_o.mul_signed_mode = 2'b10;  // MULHSU
        2'b11:   decoder_ctrl_o.mul_signed_mode = 2'b00;  // MULHU
        default: decoder_ctrl_o.mul_signed_mode = 2'b11;  // MUL, MULH
      endcase
      decoder_ctrl_o.rf_re        = 2'b11;
      decoder_ctrl_o.rf_we        = 1'b1;
      decoder_ctrl_o.illegal_insn = 1'b0;
    end
  end

endmodule

//--- rtl/rv_i_decoder.sv
`timescale 1ns/100ps

module rv_i_decoder (
  input  logic [31:0]           instr_rdata_i,   // Raw instruction word
  output rv_pkg::decoder_ctrl_t decoder_ctrl_o   // Illegal constant when nothing matches
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       op_legal;     // funct7 allowed for this OP funct3
  logic       opimm_legal;  // Shift-immediate funct7 check

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Only ADD/SUB and SRL/SRA have an alternate funct7
  assign op_legal = (funct7 == 7'h00) ||
                    ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

  assign opimm_legal = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                       (funct3 == 3'b101) ? ((funct7 == 7'h00) || (funct7 == 7'h20)) :
                       1'b1;

  // funct3 to ALU operator, alt selects SUB / SRA
  function automatic rv_pkg::alu_opcode_e alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    decoder_ctrl_o = rv_pkg::DECODER_CTRL_ILLEGAL_INSN;  // No match by default
    case (opcode)
      rv_pkg::OPCODE_OP: begin
        if (op_legal) begin
          decoder_ctrl_o.alu_en           = 1'b1;
          decoder_ctrl_o.alu_operator     = alu_op(funct3, funct7[5]);
          decoder_ctrl_o.alu_op_b_mux_sel = rv_pkg::OP_B_REGB;
          decoder_ctrl_o.rf_re            = 2'b11;   // rs1 and rs2
          decoder_ctrl_o.rf_we            = 1'b1;
          decoder_ctrl_o.illegal_insn     = 1'b0;
        end
      end
      rv_pkg::OPCODE_OPIMM: begin
        if (opimm_legal) begin
          decoder_ctrl_o.alu_en           = 1'b1;
          // imm[10] only means SRA for funct3 101
          decoder_ctrl_o.alu_operator     = alu_op(funct3, funct7[5] && (funct3 == 3'b101));
          decoder_ctrl_o.alu_op_b_mux_sel = rv_pkg::OP_B_IMM;
          decoder_ctrl_o.rf_re            = 2'b01;   // rs1 only
          decoder_ctrl_o.rf_we            = 1'b1;
          decoder_ctrl_o.illegal_insn     = 1'b0;
        end
      end
      rv_pkg::OPCODE_LUI: begin
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.alu_operator     = rv_pkg::ALU_LUI;
        decoder_ctrl_o.alu_op_b_mux_sel = rv_pkg::OP_B_IMM;  // U-type immediate
        decoder_ctrl_o.rf_we            = 1'b1;
        decoder_ctrl_o.illegal_insn     = 1'b0;
      end
      rv_pkg::OPCODE_SYSTEM: begin
        // Exact encodings, everything else in SYSTEM stays illegal
        if (instr_rdata_i == 32'h0000_0073) begin
          decoder_ctrl_o.sys_ecall_insn = 1'b1;
          decoder_ctrl_o.illegal_insn   = 1'b0;
        end else if (instr_rdata_i == 32'h0010_0073) begin
          decoder_ctrl_o.sys_ebrk_insn  = 1'b1;
          decoder_ctrl_o.illegal_insn   = 1'b0;
        end
      end
      default: ;  // Unknown opcode
    endcase
  end

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int XLEN = 32;  // Data path width

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////
  localparam logic [6:0] OPCODE_OP     = 7'h33;  // Register-register
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;  // Register-immediate
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;  // ECALL / EBREAK only

  ////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI   // Pass operand B through
  } alu_opcode_e;

  typedef enum logic [1:0] {
    MUL_L,  // Low word of product
    MUL_H   // High word of product
  } mul_opcode_e;

  typedef enum logic {
    OP_B_REGB,
    OP_B_IMM
  } alu_op_b_mux_e;

  ////////////////////////////////////////
  // Pipeline payloads
  ////////////////////////////////////////
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic        illegal_c_insn;  // Compressed expander flagged this word
  } if_id_pipe_t;

  // Common output of every subdecoder
  typedef struct packed {
    logic          alu_en;
    alu_opcode_e   alu_operator;
    alu_op_b_mux_e alu_op_b_mux_sel;
    logic          mul_en;
    mul_opcode_e   mul_operator;
    logic [1:0]    mul_signed_mode;   // [1] rs1 signed, [0] rs2 signed
    logic [1:0]    rf_re;             // [1] rs2, [0] rs1
    logic          rf_we;
    logic          sys_ecall_insn;
    logic          sys_ebrk_insn;
    logic          illegal_insn;
  } decoder_ctrl_t;

  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    alu_en           : 1'b0,
    alu_operator     : ALU_ADD,
    alu_op_b_mux_sel : OP_B_REGB,
    mul_en           : 1'b0,
    mul_operator     : MUL_L,
    mul_signed_mode  : 2'b00,
    rf_re            : 2'b00,
    rf_we            : 1'b0,
    sys_ecall_insn   : 1'b0,
    sys_ebrk_insn    : 1'b0,
    illegal_insn     : 1'b1
  };

  typedef struct packed {
    logic            valid;
    decoder_ctrl_t   ctrl;
    logic [4:0]      rd;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_rdata;
    logic [XLEN-1:0] rs2_rdata;
    logic [XLEN-1:0] imm;        // I-type or U-type, already expanded
  } id_ex_pipe_t;

  typedef struct packed {
    logic            valid;
    logic            rf_we;
    logic [4:0]      rd;
    logic [XLEN-1:0] result;
    logic            illegal_insn;
    logic            sys_ecall_insn;
    logic            sys_ebrk_insn;
  } ex_wb_pipe_t;

endpackage
